// ==== dv/code_lock_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module code_lock_tb;
    import lock_pkg::*;

    // largest of four buzzer settings
    function automatic int longest(input int a, input int b, input int c, input int d);
        int m;
        m = a;
        if (b > m) begin
            m = b;
        end
        if (c > m) begin
            m = c;
        end
        if (d > m) begin
            m = d;
        end
        return m;
    endfunction

    // lockout length in whole seconds, from the bcd constant
    localparam int LOCK_SECS      = ((`LOCK_LOCKOUT_SECS >> 4) * 10) + (`LOCK_LOCKOUT_SECS & 15);
    localparam int PRESS_CYCLES   = 8;
    localparam int MAX_PRESSES    = 64;
    localparam int MAX_HALF       = longest(`LOCK_CLICK_HALF, `LOCK_SUCCESS_HALF,
                                            `LOCK_FAIL_HALF, `LOCK_TICK_HALF);
    localparam int MAX_TONE_LEN   = longest(`LOCK_CLICK_LEN, `LOCK_SUCCESS_LEN,
                                            `LOCK_FAIL_LEN, `LOCK_TICK_LEN);
    // one press plus a wait for the previous tone to die out
    localparam int PRESS_BUDGET   = PRESS_CYCLES + 1 + MAX_TONE_LEN + MAX_HALF;
    localparam int TIMEOUT_CYCLES = MAX_PRESSES * PRESS_BUDGET
                                    + 2 * (LOCK_SECS + 2) * `LOCK_SEC_CYCLES;

    logic        clk;
    logic        reset;
    logic [15:0] onehot;
    logic [11:0] display;
    logic        unlocked;
    logic        locked_out;
    logic        buzzer;

    logic [3:0]  entry_q[$];      // model entry, first typed at the front
    logic [11:0] secret_m;
    int          tries_m;
    bit          open_m;
    bit          set_m;
    bit          lock_m;
    bit          buzz_seen;
    int          cycle_count = 0;

    code_lock_top i_code_lock_top (
        .clk        (clk),
        .reset      (reset),
        .onehot     (onehot),
        .display    (display),
        .unlocked   (unlocked),
        .locked_out (locked_out),
        .buzzer     (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // open and locked out never at once
    assert property (@(posedge clk) disable iff (reset) !(unlocked && locked_out))
        else abort_run("unlocked and locked_out are high together");

    task automatic expect_eq(input string test, input logic [11:0] expected,
                             input logic [11:0] actual);
        assert (actual === expected) else begin
            abort_run($sformatf("Fail %s expected %h actual %h", test, expected, actual));
        end
    endtask

    function automatic logic [11:0] model_display();
        logic [11:0] disp;
        disp = 12'hfff;
        for (int i = 0; i < entry_q.size(); i++) begin
            disp[4*i +: 4] = entry_q[entry_q.size() - 1 - i];  // newest lowest
        end
        return disp;
    endfunction

    function automatic logic [11:0] lockout_display(input int secs);
        return {4'hf, 4'(secs / 10), 4'(secs % 10)};
    endfunction

    function automatic logic [11:0] random_code_except(input logic [11:0] avoid);
        logic [11:0] code;
        do begin
            code = {4'($urandom % 10), 4'($urandom % 10), 4'($urandom % 10)};
        end while (code == avoid);
        return code;
    endfunction

    // applies one key to the model, returns 1 when a digit click is due
    function automatic bit update_model(input int k);
        bit          click;
        logic [11:0] entered;
        click = 1'b0;
        if (lock_m) begin
            return 1'b0;  // keys dropped in lockout
        end
        if (k <= 9) begin
            if ((!open_m || set_m) && entry_q.size() < `LOCK_DIGITS) begin
                entry_q.push_back(4'(k));
                click = 1'b1;
            end
        end else if (k == KEY_BACK) begin
            if ((!open_m || set_m) && entry_q.size() > 0) begin
                void'(entry_q.pop_back());
            end
        end else if (k == KEY_CLEAR) begin
            entry_q.delete();
            open_m = 1'b0;
            set_m  = 1'b0;
        end else if (k == KEY_SET) begin
            if (open_m) begin
                set_m = 1'b1;
                entry_q.delete();
            end
        end else if (k == KEY_ENTER && entry_q.size() == `LOCK_DIGITS) begin
            entered = {entry_q[0], entry_q[1], entry_q[2]};
            if (set_m) begin
                secret_m = entered;
                set_m    = 1'b0;
                tries_m  = 0;
                entry_q.delete();
            end else if (!open_m) begin
                entry_q.delete();
                if (entered == secret_m) begin
                    open_m  = 1'b1;
                    tries_m = 0;
                end else begin
                    tries_m++;
                    if (tries_m == `LOCK_MAX_TRIES) begin
                        tries_m = 0;
                        lock_m  = 1'b1;
                    end
                end
            end
        end
        return click;
    endfunction

    // buzzer low longer than any half-period means no tone is playing
    task automatic wait_buzzer_quiet();
        int low_run;
        low_run = 0;
        while (low_run <= MAX_HALF) begin
            @(posedge clk);
            low_run = (buzzer === 1'b0) ? low_run + 1 : 0;
        end
    endtask

    // hold a key 4 cycles, release 4 cycles, then compare with the model
    task automatic press_key(input int k, input string test);
        bit click;
        click = update_model(k);
        if (click) begin
            wait_buzzer_quiet();  // an earlier tone must not pass for this click
        end
        buzz_seen = 1'b0;
        @(posedge clk);
        onehot <= 16'h1 << k;
        repeat (PRESS_CYCLES / 2) begin
            @(posedge clk);
            buzz_seen |= buzzer;
        end
        onehot <= 16'h0;
        repeat (PRESS_CYCLES / 2) begin
            @(posedge clk);
            buzz_seen |= buzzer;
        end
        if (click) begin
            assert (buzz_seen) else begin
                abort_run($sformatf("%s: buzzer stayed low after digit %0d", test, k));
            end
        end
        expect_eq($sformatf("%s unlocked", test), 12'(open_m), 12'(unlocked));
        expect_eq($sformatf("%s locked_out", test), 12'(lock_m), 12'(locked_out));
        if (!lock_m) begin
            expect_eq($sformatf("%s display", test), model_display(), display);
        end
    endtask

    task automatic type_code(input logic [11:0] code, input string test);
        press_key(int'(code[11:8]), test);
        press_key(int'(code[7:4]), test);
        press_key(int'(code[3:0]), test);
    endtask

    task automatic wait_display_change(output int cycles);
        logic [11:0] old;
        old    = display;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (display === old);
    endtask

    initial begin
        logic [11:0] old_code;
        logic [11:0] new_code;
        int          gap;
        reset    <= 1'b1;
        onehot   <= 16'h0;
        secret_m  = `LOCK_DEFAULT_CODE;
        tries_m   = 0;
        open_m    = 1'b0;
        set_m     = 1'b0;
        lock_m    = 1'b0;
        void'($urandom(32'hc8da));
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);

        // idle after reset
        expect_eq("reset display", 12'hfff, display);
        expect_eq("reset unlocked", 12'h0, 12'(unlocked));
        expect_eq("reset locked_out", 12'h0, 12'(locked_out));
        expect_eq("reset buzzer", 12'h0, 12'(buzzer));

        // shifting, overflow, back and clear
        type_code(12'h123, "entry");
        press_key(4, "fourth digit");
        press_key(KEY_BACK, "back");
        press_key(KEY_CLEAR, "clear");

        // short entry, then the default code
        press_key(2, "short entry");
        press_key(4, "short entry");
        press_key(KEY_ENTER, "short entry");
        press_key(KEY_CLEAR, "short entry");
        type_code(`LOCK_DEFAULT_CODE, "default code");
        press_key(KEY_ENTER, "default code");

        // new secret while open
        old_code = secret_m;
        new_code = random_code_except(secret_m);
        press_key(KEY_SET, "set code");
        type_code(new_code, "set code");
        press_key(KEY_ENTER, "set code");
        press_key(KEY_CLEAR, "set code");
        type_code(old_code, "old code");
        press_key(KEY_ENTER, "old code");
        type_code(new_code, "new code");
        press_key(KEY_ENTER, "new code");

        // three wrong codes start the lockout
        press_key(KEY_CLEAR, "lockout");
        repeat (`LOCK_MAX_TRIES) begin
            type_code(random_code_except(secret_m), "wrong code");
            press_key(KEY_ENTER, "wrong code");
        end
        expect_eq("lockout start", lockout_display(LOCK_SECS), display);
        press_key(7, "key in lockout");
        expect_eq("key in lockout", lockout_display(LOCK_SECS), display);

        for (int s = LOCK_SECS - 1; s >= 0; s--) begin
            wait_display_change(gap);
            if (s > 0) begin
                expect_eq("countdown", lockout_display(s), display);
                expect_eq("countdown locked_out", 12'h1, 12'(locked_out));
            end else begin
                expect_eq("countdown end", 12'hfff, display);
            end
            if (s < LOCK_SECS - 1) begin
                expect_eq("tick spacing", 12'(`LOCK_SEC_CYCLES), 12'(gap));
            end
        end
        repeat (3) @(posedge clk);
        expect_eq("lockout end", 12'h0, 12'(locked_out));
        lock_m = 1'b0;
        type_code(secret_m, "after lockout");
        press_key(KEY_ENTER, "after lockout");

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/lock_pkg.sv
logic/keypad_decoder.sv
logic/entry_buffer.sv
logic/lockout_timer.sv
logic/lock_controller.sv
logic/alert_tone.sv
logic/code_lock_top.sv
dv/code_lock_tb.sv

// ==== logic/alert_tone.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module alert_tone (
    input  wire             clk,
    input  wire             reset,
    input  wire  lock_pkg::tone_e tone_req,
    output logic            buzzer
);
    import lock_pkg::*;

    logic [`LOCK_TONE_CW-1:0] req_half;
    logic [`LOCK_TONE_CW-1:0] req_len;
    logic [`LOCK_TONE_CW-1:0] half;      // latched half-period
    logic [`LOCK_TONE_CW-1:0] phase;
    logic [`LOCK_TONE_CW-1:0] len_left;
    logic                     active;

    // pitch and length per event
    always_comb begin
        case (tone_req)
            TONE_CLICK:   begin req_half = `LOCK_CLICK_HALF;   req_len = `LOCK_CLICK_LEN;   end
            TONE_SUCCESS: begin req_half = `LOCK_SUCCESS_HALF; req_len = `LOCK_SUCCESS_LEN; end
            TONE_FAIL:    begin req_half = `LOCK_FAIL_HALF;    req_len = `LOCK_FAIL_LEN;    end
            TONE_TICK:    begin req_half = `LOCK_TICK_HALF;    req_len = `LOCK_TICK_LEN;    end
            default:      begin req_half = '0;                 req_len = '0;                end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            buzzer <= 1'b0;
        end else if (tone_req != TONE_NONE) begin
            active <= 1'b1;  // restart pattern
            buzzer <= 1'b1;
        end else if (active) begin
            if (len_left == '0) begin
                active <= 1'b0;
                buzzer <= 1'b0;
            end else if (phase == half - 1'b1) begin
                buzzer <= ~buzzer;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tone_req != TONE_NONE) begin
            half     <= req_half;
            phase    <= '0;
            len_left <= req_len - 1'b1;
        end else if (active) begin
            phase    <= (phase == half - 1'b1) ? '0 : phase + 1'b1;
            len_left <= len_left - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/code_lock_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module code_lock_top (
    input  wire         clk,
    input  wire         reset,
    input  wire  [15:0] onehot,
    output logic [11:0] display,
    output logic        unlocked,
    output logic        locked_out,
    output logic        buzzer
);
    import lock_pkg::*;

    logic                          key_valid;
    key_code_e                     key;
    logic                          accept_key;
    logic                          entry_clear;
    bcd_digit_t [`LOCK_DIGITS-1:0] entry_digits;
    logic                          entry_full;
    logic                          lockout_start;
    logic                          lockout_active;
    logic                          sec_tick;
    bcd_digit_t [1:0]              remaining;
    tone_e                         tone_req;

    keypad_decoder i_keypad_decoder (
        .clk       (clk),
        .reset     (reset),
        .onehot    (onehot),
        .key_valid (key_valid),
        .key       (key)
    );

    entry_buffer i_entry_buffer (
        .clk          (clk),
        .reset        (reset),
        .key_valid    (key_valid),
        .key          (key),
        .accept_key   (accept_key),
        .entry_clear  (entry_clear),
        .entry_digits (entry_digits),
        .entry_full   (entry_full)
    );

    lockout_timer i_lockout_timer (
        .clk            (clk),
        .reset          (reset),
        .lockout_start  (lockout_start),
        .lockout_active (lockout_active),
        .sec_tick       (sec_tick),
        .remaining      (remaining)
    );

    lock_controller i_lock_controller (
        .clk            (clk),
        .reset          (reset),
        .key_valid      (key_valid),
        .key            (key),
        .entry_digits   (entry_digits),
        .entry_full     (entry_full),
        .lockout_active (lockout_active),
        .sec_tick       (sec_tick),
        .remaining      (remaining),
        .accept_key     (accept_key),
        .entry_clear    (entry_clear),
        .lockout_start  (lockout_start),
        .unlocked       (unlocked),
        .locked_out     (locked_out),
        .tone_req       (tone_req),
        .display        (display)
    );

    alert_tone i_alert_tone (
        .clk      (clk),
        .reset    (reset),
        .tone_req (tone_req),
        .buzzer   (buzzer)
    );

endmodule

`default_nettype wire

// ==== logic/entry_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module entry_buffer (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire                                         key_valid,
    input  wire  lock_pkg::key_code_e                   key,
    input  wire                                         accept_key,
    input  wire                                         entry_clear,
    output lock_pkg::bcd_digit_t [`LOCK_DIGITS-1:0]     entry_digits,
    output logic                                        entry_full
);
    import lock_pkg::*;

    localparam int CW = $clog2(`LOCK_DIGITS + 1);

    logic [CW-1:0] count;  // digits held

    assign entry_full = (count == CW'(`LOCK_DIGITS));

    always_ff @(posedge clk) begin
        if (reset || entry_clear) begin
            entry_digits <= {`LOCK_DIGITS{`LOCK_BLANK}};
            count        <= '0;
        end else if (key_valid && key == KEY_CLEAR) begin
            entry_digits <= {`LOCK_DIGITS{`LOCK_BLANK}};
            count        <= '0;
        end else if (key_valid && accept_key) begin
            if (key <= KEY_D9) begin
                if (!entry_full) begin
                    // newest digit at the low position
                    entry_digits <= {entry_digits[`LOCK_DIGITS-2:0], bcd_digit_t'(key)};
                    count        <= count + 1'b1;
                end
            end else if (key == KEY_BACK) begin
                if (count != '0) begin
                    entry_digits <= {`LOCK_BLANK, entry_digits[`LOCK_DIGITS-1:1]};
                    count        <= count - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/keypad_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypad_decoder (
    input  wire                 clk,
    input  wire                 reset,
    input  wire  [15:0]         onehot,
    output logic                key_valid,
    output lock_pkg::key_code_e key
);
    import lock_pkg::*;

    localparam int KEY_LINES = 14;  // lines 14 and 15 carry no key

    logic [15:0] onehot_q;
    logic [15:0] prev_q;
    logic        single_hot;
    logic [3:0]  hot_idx;

    // exactly one bit set, and only on a mapped line
    assign single_hot = (onehot_q[15:KEY_LINES] == '0) &&
                        (onehot_q != 16'h0) &&
                        ((onehot_q & (onehot_q - 16'h1)) == 16'h0);

    always_comb begin
        hot_idx = 4'd0;
        for (int i = 0; i < KEY_LINES; i++) begin
            if (onehot_q[i]) begin
                hot_idx = 4'(i);  // line number is the key code
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            onehot_q  <= 16'h0;
            prev_q    <= 16'h0;
            key_valid <= 1'b0;
        end else begin
            onehot_q  <= onehot;  // input register
            key_valid <= single_hot && (onehot_q != prev_q);
            // release or bad code forgets the last key
            prev_q    <= single_hot ? onehot_q : 16'h0;
        end
    end

    always_ff @(posedge clk) begin
        key <= key_code_e'(hot_idx);
    end

endmodule

`default_nettype wire

// ==== logic/lock_consts.svh ====
`ifndef LOCK_CONSTS_SVH
`define LOCK_CONSTS_SVH

// code entry
`define LOCK_DIGITS        3
`define LOCK_MAX_TRIES     3
`define LOCK_DEFAULT_CODE  12'h246
`define LOCK_BLANK         4'hf        // blank display position

// lockout, seconds held as bcd tens and units
`define LOCK_LOCKOUT_SECS  8'h20
`define LOCK_SEC_CYCLES    64          // small for simulation

// buzzer patterns, half-period and total length in cycles
`define LOCK_CLICK_HALF    2
`define LOCK_CLICK_LEN     8
`define LOCK_SUCCESS_HALF  3
`define LOCK_SUCCESS_LEN   30
`define LOCK_FAIL_HALF     6
`define LOCK_FAIL_LEN      40
`define LOCK_TICK_HALF     2
`define LOCK_TICK_LEN      12

// counter width inside the tone generator
`define LOCK_TONE_CW       16

`endif

// ==== logic/lock_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module lock_controller (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire                                        key_valid,
    input  wire  lock_pkg::key_code_e                  key,
    input  wire  lock_pkg::bcd_digit_t [`LOCK_DIGITS-1:0] entry_digits,
    input  wire                                        entry_full,
    input  wire                                        lockout_active,
    input  wire                                        sec_tick,
    input  wire  lock_pkg::bcd_digit_t [1:0]           remaining,
    output logic                                       accept_key,
    output logic                                       entry_clear,
    output logic                                       lockout_start,
    output logic                                       unlocked,
    output logic                                       locked_out,
    output lock_pkg::tone_e                            tone_req,
    output logic [11:0]                                display
);
    import lock_pkg::*;

    localparam int TW = $clog2(`LOCK_MAX_TRIES + 1);

    bcd_digit_t [`LOCK_DIGITS-1:0] secret;
    logic [TW-1:0]                 tries;     // wrong codes in a row
    logic                          set_mode;  // next entry becomes the secret

    assign accept_key = set_mode || (!unlocked && !locked_out);
    assign display    = lockout_active ? {`LOCK_BLANK, remaining} : entry_digits;

    always_ff @(posedge clk) begin
        if (reset) begin
            secret        <= `LOCK_DEFAULT_CODE;
            tries         <= '0;
            set_mode      <= 1'b0;
            unlocked      <= 1'b0;
            locked_out    <= 1'b0;
            entry_clear   <= 1'b0;
            lockout_start <= 1'b0;
            tone_req      <= TONE_NONE;
        end else begin
            entry_clear   <= 1'b0;
            lockout_start <= 1'b0;
            tone_req      <= sec_tick ? TONE_TICK : TONE_NONE;
            if (locked_out && !lockout_active && !lockout_start) begin
                locked_out <= 1'b0;  // countdown finished
            end
            if (key_valid && !locked_out) begin
                case (key)
                    KEY_ENTER: begin
                        if (set_mode && entry_full) begin
                            secret      <= entry_digits;
                            set_mode    <= 1'b0;
                            tries       <= '0;
                            tone_req    <= TONE_SUCCESS;
                            entry_clear <= 1'b1;
                        end else if (!unlocked && entry_full) begin
                            entry_clear <= 1'b1;
                            if (entry_digits == secret) begin
                                unlocked <= 1'b1;
                                tries    <= '0;
                                tone_req <= TONE_SUCCESS;
                            end else begin
                                tone_req <= TONE_FAIL;
                                if (tries == TW'(`LOCK_MAX_TRIES - 1)) begin
                                    tries         <= '0;
                                    locked_out    <= 1'b1;
                                    lockout_start <= 1'b1;
                                end else begin
                                    tries <= tries + 1'b1;
                                end
                            end
                        end
                    end
                    KEY_SET: begin
                        if (unlocked) begin
                            set_mode    <= 1'b1;
                            entry_clear <= 1'b1;
                        end
                    end
                    KEY_CLEAR: begin
                        entry_clear <= 1'b1;
                        unlocked    <= 1'b0;  // relock
                        set_mode    <= 1'b0;
                    end
                    KEY_BACK: begin
                        if (accept_key) tone_req <= TONE_CLICK;
                    end
                    default: begin  // digits
                        if (accept_key && !entry_full) tone_req <= TONE_CLICK;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/lock_pkg.sv ====
`default_nettype none

package lock_pkg;

    // decoded key, digits first so the value is the digit itself
    typedef enum logic [3:0] {
        KEY_D0    = 4'd0,
        KEY_D1    = 4'd1,
        KEY_D2    = 4'd2,
        KEY_D3    = 4'd3,
        KEY_D4    = 4'd4,
        KEY_D5    = 4'd5,
        KEY_D6    = 4'd6,
        KEY_D7    = 4'd7,
        KEY_D8    = 4'd8,
        KEY_D9    = 4'd9,
        KEY_BACK  = 4'd10,
        KEY_ENTER = 4'd11,
        KEY_CLEAR = 4'd12,
        KEY_SET   = 4'd13
    } key_code_e;

    typedef logic [3:0] bcd_digit_t;  // 4'hf shows as blank

    typedef enum logic [2:0] {
        TONE_NONE,
        TONE_CLICK,
        TONE_SUCCESS,
        TONE_FAIL,
        TONE_TICK
    } tone_e;

endpackage

`default_nettype wire

// ==== logic/lockout_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module lockout_timer (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        lockout_start,
    output logic                       lockout_active,
    output logic                       sec_tick,
    output lock_pkg::bcd_digit_t [1:0] remaining
);
    import lock_pkg::*;

    localparam int DW = $clog2(`LOCK_SEC_CYCLES);

    logic [DW-1:0] div_cnt;
    logic          sec_end;

    assign sec_end = (div_cnt == DW'(`LOCK_SEC_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            lockout_active <= 1'b0;
            sec_tick       <= 1'b0;
            div_cnt        <= '0;
        end else begin
            sec_tick <= 1'b0;
            if (lockout_start) begin
                lockout_active <= 1'b1;
                div_cnt        <= '0;
            end else if (lockout_active) begin
                div_cnt <= sec_end ? '0 : div_cnt + 1'b1;
                if (sec_end) begin
                    sec_tick <= 1'b1;
                    // this tick reaches 00
                    if (remaining == {4'h0, 4'h1}) begin
                        lockout_active <= 1'b0;
                    end
                end
            end
        end
    end

    // bcd countdown, borrow from tens
    always_ff @(posedge clk) begin
        if (lockout_start) begin
            remaining <= `LOCK_LOCKOUT_SECS;
        end else if (lockout_active && sec_end && remaining != 8'h00) begin
            if (remaining[0] == 4'h0) begin
                remaining[1] <= remaining[1] - 4'h1;
                remaining[0] <= 4'h9;
            end else begin
                remaining[0] <= remaining[0] - 4'h1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the code lock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module code_lock_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcode_lock_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
